// ==== src/des_pkg.sv ====
package des_pkg;

	// tables use standard DES numbering, bit 1 is the MSB
	// standard bit n of a W-bit vector sits at index [W-n]

	localparam int BLOCK_W    = 64;
	localparam int HALF_W     = 32;
	localparam int KEY_HALF_W = 28;
	localparam int SUBKEY_W   = 48;
	localparam int NUM_ROUNDS = 16;
	localparam int ROUND_W    = 4;
	localparam int LATENCY    = 17;	// start accepted to done

	typedef logic [BLOCK_W-1:0]    block_t;
	typedef logic [HALF_W-1:0]     half_t;
	typedef logic [KEY_HALF_W-1:0] key_half_t;
	typedef logic [SUBKEY_W-1:0]   subkey_t;
	typedef logic [ROUND_W-1:0]    round_t;

	// ------------------------------------------------------------------------
	// permutations, entry i is the source bit of output bit i+1

	localparam int IP_TABLE [BLOCK_W] = '{
		58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
		62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
		57, 49, 41, 33, 25, 17,  9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
		61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
	};

	localparam int FP_TABLE [BLOCK_W] = '{
		40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
		38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
		36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
		34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41,  9, 49, 17, 57, 25
	};

	localparam int PC1_TABLE [2*KEY_HALF_W] = '{
		57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
		10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
		14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
	};

	localparam int PC2_TABLE [SUBKEY_W] = '{
		14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
		23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
		41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
	};

	localparam int E_TABLE [SUBKEY_W] = '{
		32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
		 8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
		16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
		24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
	};

	localparam int P_TABLE [HALF_W] = '{
		16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
		 2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
	};

	// one-bit rotation rounds, index 0 is round 1
	localparam bit SHIFT_ONE [NUM_ROUNDS] = '{
		1, 1, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 1
	};

	// ------------------------------------------------------------------------
	// s-boxes, entry index is {row, column}

	localparam logic [3:0] SBOX_TABLE [8][64] = '{
		'{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
		   0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
		   4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
		  15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
		'{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
		   3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
		   0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
		  13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
		'{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
		  13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
		  13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
		   1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
		'{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
		  13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
		  10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
		   3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
		'{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
		  14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
		   4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
		  11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
		'{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
		  10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
		   9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
		   4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
		'{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
		  13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
		   1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
		   6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
		'{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
		   1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
		   7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
		   2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
	};

endpackage

// ==== src/des_round_function.sv ====
`timescale 1ns/1ps

module des_round_function (
	input  des_pkg::half_t   i_R,
	input  des_pkg::subkey_t i_Subkey,
	output des_pkg::half_t   o_F
);

	des_pkg::subkey_t w_expand;
	des_pkg::subkey_t w_mix;
	des_pkg::half_t   w_sbox;

	// ------------------------------------------------------------------------
	// expansion and key mix

	always_comb begin
		for (int i = 0; i < des_pkg::SUBKEY_W; i++)
			w_expand[des_pkg::SUBKEY_W-1-i] = i_R[des_pkg::HALF_W - des_pkg::E_TABLE[i]];
	end

	assign w_mix = w_expand ^ i_Subkey;

	// ------------------------------------------------------------------------
	// s-box lookups, box 1 takes the top six bits

	always_comb begin
		logic [5:0] grp;
		for (int b = 0; b < 8; b++) begin
			grp = w_mix[des_pkg::SUBKEY_W-1-6*b -: 6];
			w_sbox[des_pkg::HALF_W-1-4*b -: 4] = des_pkg::SBOX_TABLE[b][{grp[5], grp[0], grp[4:1]}];
		end
	end

	// P permutation
	always_comb begin
		for (int i = 0; i < des_pkg::HALF_W; i++)
			o_F[des_pkg::HALF_W-1-i] = w_sbox[des_pkg::HALF_W - des_pkg::P_TABLE[i]];
	end

endmodule

// ==== src/des_key_schedule.sv ====
`timescale 1ns/1ps

module des_key_schedule (
	input  logic             i_Clk,
	input  logic             i_Rst,
	input  logic             i_Load,
	input  logic             i_Step,
	input  logic             i_Dec,
	input  des_pkg::block_t  i_Key,
	input  des_pkg::round_t  i_Round,
	output des_pkg::subkey_t o_Subkey
);

	logic [2*des_pkg::KEY_HALF_W-1:0] w_pc1;
	logic [2*des_pkg::KEY_HALF_W-1:0] w_cd;
	des_pkg::key_half_t r_c, r_d;
	des_pkg::round_t    w_next;		// next encrypt round
	des_pkg::round_t    w_mirror;	// round being undone on decrypt
	logic               r_dec;
	logic               w_one;

	function automatic des_pkg::key_half_t rotate(input des_pkg::key_half_t x,
			input logic right, input logic one);
		int n;
		n = one ? 1 : 2;
		if (right)
			rotate = (x >> n) | (x << (des_pkg::KEY_HALF_W - n));
		else
			rotate = (x << n) | (x >> (des_pkg::KEY_HALF_W - n));
	endfunction

	always_comb begin
		for (int i = 0; i < 2*des_pkg::KEY_HALF_W; i++)
			w_pc1[2*des_pkg::KEY_HALF_W-1-i] = i_Key[des_pkg::BLOCK_W - des_pkg::PC1_TABLE[i]];
	end

	assign w_next   = i_Round + 1'b1;	// wraps after the last round
	assign w_mirror = ~i_Round;
	assign w_one    = r_dec ? des_pkg::SHIFT_ONE[w_mirror] : des_pkg::SHIFT_ONE[w_next];

	always_ff @(posedge i_Clk or negedge i_Rst) begin
		if (!i_Rst)
			r_dec <= 1'b0;
		else if (i_Load)
			r_dec <= i_Dec;
	end

	// encrypt loads C1/D1 while decrypt loads C16/D16 which equal C0/D0
	always_ff @(posedge i_Clk) begin
		if (i_Load) begin
			r_c <= i_Dec ? w_pc1[55:28] : rotate(w_pc1[55:28], 1'b0, 1'b1);
			r_d <= i_Dec ? w_pc1[27:0] : rotate(w_pc1[27:0], 1'b0, 1'b1);
		end else if (i_Step) begin
			r_c <= rotate(r_c, r_dec, w_one);
			r_d <= rotate(r_d, r_dec, w_one);
		end
	end

	assign w_cd = {r_c, r_d};

	always_comb begin
		for (int i = 0; i < des_pkg::SUBKEY_W; i++)
			o_Subkey[des_pkg::SUBKEY_W-1-i] = w_cd[2*des_pkg::KEY_HALF_W - des_pkg::PC2_TABLE[i]];
	end

endmodule

// ==== src/des_control.sv ====
`timescale 1ns/1ps

module des_control (
	input  logic            i_Clk,
	input  logic            i_Rst,
	input  logic            i_Start,
	input  des_pkg::block_t i_Text,
	input  des_pkg::half_t  i_F,
	output logic            o_Load,
	output logic            o_Step,
	output des_pkg::round_t o_Round,
	output des_pkg::half_t  o_R,
	output logic            o_Busy,
	output logic            o_Done,
	output des_pkg::block_t o_Text
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ROUND,
		S_FINISH
	} state_t;

	state_t          r_state;
	des_pkg::round_t r_round;
	des_pkg::half_t  r_l, r_r;
	des_pkg::block_t w_ip, w_fp;
	des_pkg::block_t w_preout;
	logic            w_last;

	// ------------------------------------------------------------------------
	// initial and final permutations

	assign w_preout = {r_r, r_l};

	always_comb begin
		for (int i = 0; i < des_pkg::BLOCK_W; i++) begin
			w_ip[des_pkg::BLOCK_W-1-i] = i_Text[des_pkg::BLOCK_W - des_pkg::IP_TABLE[i]];
			w_fp[des_pkg::BLOCK_W-1-i] = w_preout[des_pkg::BLOCK_W - des_pkg::FP_TABLE[i]];
		end
	end

	assign o_Load  = i_Start && (r_state == S_IDLE);
	assign o_Step  = (r_state == S_ROUND);
	assign o_Busy  = (r_state != S_IDLE);
	assign o_Round = r_round;
	assign o_R     = r_r;
	assign w_last  = (r_round == des_pkg::round_t'(des_pkg::NUM_ROUNDS - 1));

	// ------------------------------------------------------------------------
	// sequencer

	always_ff @(posedge i_Clk or negedge i_Rst) begin
		if (!i_Rst) begin
			r_state <= S_IDLE;
			r_round <= '0;
			o_Done  <= 1'b0;
			o_Text  <= '0;
		end else begin
			o_Done <= 1'b0;
			case (r_state)
				S_IDLE: begin
					r_round <= '0;
					if (i_Start)
						r_state <= S_ROUND;
				end
				S_ROUND: begin
					r_round <= r_round + 1'b1;
					if (w_last)
						r_state <= S_FINISH;
				end
				default: begin
					o_Text  <= w_fp;	// swapped halves
					o_Done  <= 1'b1;
					r_state <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_Clk) begin
		if (o_Load) begin
			r_l <= w_ip[des_pkg::BLOCK_W-1:des_pkg::HALF_W];
			r_r <= w_ip[des_pkg::HALF_W-1:0];
		end else if (o_Step) begin
			r_l <= r_r;
			r_r <= r_l ^ i_F;	// feistel
		end
	end

endmodule

// ==== src/des_core.sv ====
`timescale 1ns/1ps

module des_core (
	input  logic            i_Clk,
	input  logic            i_Rst,
	input  logic            i_Start,
	input  logic            i_Dec,
	input  des_pkg::block_t i_Key,
	input  des_pkg::block_t i_Text,
	output logic            o_Busy,
	output logic            o_Done,
	output des_pkg::block_t o_Text
);

	logic             w_load;
	logic             w_step;
	des_pkg::round_t  w_round;
	des_pkg::subkey_t w_subkey;
	des_pkg::half_t   w_r_half;
	des_pkg::half_t   w_f_out;

	des_control u_control (
		.i_Clk   (i_Clk),
		.i_Rst   (i_Rst),
		.i_Start (i_Start),
		.i_Text  (i_Text),
		.i_F     (w_f_out),
		.o_Load  (w_load),
		.o_Step  (w_step),
		.o_Round (w_round),
		.o_R     (w_r_half),
		.o_Busy  (o_Busy),
		.o_Done  (o_Done),
		.o_Text  (o_Text)
	);

	// key and direction only reach the key schedule
	des_key_schedule u_key_schedule (
		.i_Clk    (i_Clk),
		.i_Rst    (i_Rst),
		.i_Load   (w_load),
		.i_Step   (w_step),
		.i_Dec    (i_Dec),
		.i_Key    (i_Key),
		.i_Round  (w_round),
		.o_Subkey (w_subkey)
	);

	des_round_function u_round_function (
		.i_R      (w_r_half),
		.i_Subkey (w_subkey),
		.o_F      (w_f_out)
	);

endmodule

// ==== dv/des_props.sv ====
`timescale 1ns/1ps

module des_props (
	input logic i_Clk,
	input logic i_Rst,
	input logic i_Start,
	input logic i_Busy,
	input logic i_Done
);

	int fail_count = 0;

	// sequencer stays idle once reset is seen
	a_reset_quiet: assert property (@(posedge i_Clk) !i_Rst |=> !i_Busy && !i_Done)
		else begin
			fail_count++;
			$error("busy or done high during reset");
		end

	a_done_pulse: assert property (@(posedge i_Clk) disable iff (!i_Rst)
		i_Done |=> !i_Done)
		else begin
			fail_count++;
			$error("done lasted longer than one cycle");
		end

	a_done_idle: assert property (@(posedge i_Clk) disable iff (!i_Rst)
		!(i_Done && i_Busy))
		else begin
			fail_count++;
			$error("done and busy high together");
		end

	// done is set by the LATENCY-th edge and sampled one edge later
	a_latency: assert property (@(posedge i_Clk) disable iff (!i_Rst)
		i_Start && !i_Busy |-> ##(des_pkg::LATENCY + 1) i_Done)
		else begin
			fail_count++;
			$error("done did not follow an accepted start after the fixed latency");
		end

endmodule

// ==== dv/des_tb.sv ====
`timescale 1ns/1ps

module des_tb;

	localparam int NUM_RANDOM = 200;
	localparam int NUM_TRIPS  = 16;
	localparam int NUM_OPS    = 2 + NUM_RANDOM + 2*NUM_TRIPS + 4;
	localparam int WATCHDOG   = NUM_OPS * (des_pkg::LATENCY + 4) + 50;

	logic            i_Clk, i_Rst, i_Start, i_Dec;
	des_pkg::block_t i_Key, i_Text, o_Text;
	logic            o_Busy, o_Done;
	logic [15:0]     lfsr = 16'd65;
	logic            done_seen = 1'b0;
	int              err_count = 0;
	int              check_count = 0;

	des_core UUT (.*);

	bind des_control des_props u_props (
		.i_Clk   (i_Clk),
		.i_Rst   (i_Rst),
		.i_Start (i_Start),
		.i_Busy  (o_Busy),
		.i_Done  (o_Done)
	);

	always #5 i_Clk = ~i_Clk;

	// ------------------------------------------------------------------------
	// stimulus helpers

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[62:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		check_count++;
		assert (got === exp) else begin
			err_count++;
			$display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ------------------------------------------------------------------------
	// reference model builds all subkeys before the 16 rounds

	task automatic des_reference(input logic [63:0] key, input logic [63:0] text,
			input logic dec, output logic [63:0] result);
		logic [55:0] cd;
		logic [27:0] c, d;
		logic [47:0] ks [16];
		logic [47:0] e;
		logic [63:0] blk;
		logic [31:0] l, r, s, f;
		logic [5:0]  g;
		for (int i = 0; i < 56; i++)
			cd[55-i] = key[64 - des_pkg::PC1_TABLE[i]];
		c = cd[55:28];
		d = cd[27:0];
		for (int n = 0; n < 16; n++) begin
			repeat (des_pkg::SHIFT_ONE[n] ? 1 : 2) begin
				c = {c[26:0], c[27]};
				d = {d[26:0], d[27]};
			end
			cd = {c, d};
			for (int i = 0; i < 48; i++)
				ks[n][47-i] = cd[56 - des_pkg::PC2_TABLE[i]];
		end
		for (int i = 0; i < 64; i++)
			blk[63-i] = text[64 - des_pkg::IP_TABLE[i]];
		l = blk[63:32];
		r = blk[31:0];
		for (int n = 0; n < 16; n++) begin
			for (int i = 0; i < 48; i++)
				e[47-i] = r[32 - des_pkg::E_TABLE[i]];
			e = e ^ ks[dec ? 15 - n : n];	// decrypt walks the keys backwards
			for (int b = 0; b < 8; b++) begin
				g = e[47 - 6*b -: 6];
				s[31 - 4*b -: 4] = des_pkg::SBOX_TABLE[b][{g[5], g[0], g[4:1]}];
			end
			for (int i = 0; i < 32; i++)
				f[31-i] = s[32 - des_pkg::P_TABLE[i]];
			f = l ^ f;
			l = r;
			r = f;
		end
		blk = {r, l};
		for (int i = 0; i < 64; i++)
			result[63-i] = blk[64 - des_pkg::FP_TABLE[i]];
	endtask

	// ------------------------------------------------------------------------
	// one start pulse and a wait for done

	task automatic run_operation(input logic [63:0] key, input logic [63:0] text,
			input logic dec, output logic [63:0] result);
		int lat;
		@(posedge i_Clk);
		i_Key   <= key;
		i_Text  <= text;
		i_Dec   <= dec;
		i_Start <= 1'b1;
		@(posedge i_Clk);	// accepting edge
		i_Start <= 1'b0;
		lat = 0;
		do begin
			@(posedge i_Clk);
			lat++;
			@(negedge i_Clk);
		end while (!o_Done && lat < 2 * des_pkg::LATENCY);
		assert (o_Done) else begin
			err_count++;
			$display("no done pulse came within %0d cycles of the start", lat);
		end
		check_value("latency", 64'(lat), 64'(des_pkg::LATENCY));
		result = o_Text;
	endtask

	task automatic run_and_compare(input logic [63:0] key, input logic [63:0] text,
			input logic dec, output logic [63:0] result);
		logic [63:0] exp;
		des_reference(key, text, dec, exp);
		run_operation(key, text, dec, result);
		check_value(dec ? "decrypt" : "encrypt", result, exp);
	endtask

	// done is a single pulse and never overlaps busy
	always @(negedge i_Clk) begin
		if (i_Rst) begin
			assert (!(o_Done && o_Busy)) else begin
				err_count++;
				$display("ERROR %0t: done and busy high together", $time);
			end
			assert (!(o_Done && done_seen)) else begin
				err_count++;
				$display("ERROR %0t: done high for more than one cycle", $time);
			end
		end
		done_seen = o_Done;
	end

	initial begin
		logic [63:0] key, text, res, back, bits;
		int dones;
		int prop_fails;
		i_Clk   = 1'b0;
		i_Rst   = 1'b0;
		i_Start = 1'b0;
		i_Dec   = 1'b0;
		i_Key   = '0;
		i_Text  = '0;
		repeat (8) @(posedge i_Clk);
		i_Rst <= 1'b1;

		// published vector is checked against the model too
		des_reference(64'h133457799BBCDFF1, 64'h0123456789ABCDEF, 1'b0, res);
		check_value("model known answer", res, 64'h85E813540F0AB405);
		run_operation(64'h133457799BBCDFF1, 64'h0123456789ABCDEF, 1'b0, res);
		check_value("known answer encrypt", res, 64'h85E813540F0AB405);
		run_operation(64'h133457799BBCDFF1, 64'h85E813540F0AB405, 1'b1, res);
		check_value("known answer decrypt", res, 64'h0123456789ABCDEF);

		for (int n = 0; n < NUM_RANDOM; n++) begin
			draw_bits(64, key);
			draw_bits(64, text);
			draw_bits(1, bits);
			run_and_compare(key, text, bits[0], res);
		end

		for (int n = 0; n < NUM_TRIPS; n++) begin
			draw_bits(64, key);
			draw_bits(64, text);
			run_and_compare(key, text, 1'b0, res);
			run_operation(key, res, 1'b1, back);
			check_value("round trip", back, text);
		end

		// second start lands mid-operation
		draw_bits(64, key);
		draw_bits(64, text);
		des_reference(key, text, 1'b0, back);
		@(posedge i_Clk);
		i_Key   <= key;
		i_Text  <= text;
		i_Dec   <= 1'b0;
		i_Start <= 1'b1;
		@(posedge i_Clk);
		i_Start <= 1'b0;
		repeat (5) @(posedge i_Clk);
		i_Text  <= ~text;
		i_Start <= 1'b1;
		@(posedge i_Clk);
		i_Start <= 1'b0;
		dones = 0;
		repeat (des_pkg::LATENCY + 8) begin
			@(negedge i_Clk);
			if (o_Done) begin
				dones++;
				check_value("result with second start", o_Text, back);
			end
		end
		check_value("done pulses", 64'(dones), 64'd1);
		check_value("held result", o_Text, back);

		// ------------------------------------------------------------------------
		// reset in the middle of an operation
		@(posedge i_Clk);
		i_Text  <= text;
		i_Start <= 1'b1;
		@(posedge i_Clk);
		i_Start <= 1'b0;
		repeat (6) @(posedge i_Clk);
		i_Rst <= 1'b0;
		@(negedge i_Clk);
		check_value("busy in reset", 64'(o_Busy), 64'd0);
		check_value("done in reset", 64'(o_Done), 64'd0);
		check_value("result in reset", o_Text, 64'd0);
		repeat (8) @(posedge i_Clk);
		i_Rst <= 1'b1;
		run_and_compare(key, text, 1'b1, res);

		prop_fails = UUT.u_control.u_props.fail_count;
		$display("checks %0d, errors %0d, property failures %0d",
			check_count, err_count, prop_fails);
		if (err_count == 0 && prop_fails == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial begin
		repeat (WATCHDOG) @(posedge i_Clk);
		$display("watchdog expired after %0d cycles, the test did not finish", WATCHDOG);
		$display("checks %0d, errors %0d, property failures %0d",
			check_count, err_count, UUT.u_control.u_props.fail_count);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== sim.f ====
src/des_pkg.sv
src/des_round_function.sv
src/des_key_schedule.sv
src/des_control.sv
src/des_core.sv
dv/des_props.sv
dv/des_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= des_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# the run passes only if the log holds the pass message
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
